// File: filelist.f
rtl/mon_pkg.sv
rtl/event_sampler.sv
rtl/event_counter.sv
rtl/mon_regs.sv
rtl/traffic_monitor.sv
test/traffic_monitor_assert.sv
test/tb_traffic_monitor.sv

// File: run_sim.sh
#!/bin/sh
# build and run the traffic monitor testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir

verilator --binary --timing --assert -Wno-fatal \
   --top-module tb_traffic_monitor \
   -f filelist.f \
   -o sim_traffic_monitor

./obj_dir/sim_traffic_monitor > sim.log 2>&1
cat sim.log

if grep -q "sim passed" sim.log; then
   echo "run_sim: pass"
   exit 0
else
   echo "run_sim: fail"
   exit 1
fi

// File: test/tb_traffic_monitor.sv
/*
  traffic monitor testbench
  directed tests over the slave port and the link event lines,
  expected counts kept in the testbench from the event rules
*/
`timescale 1ns/10ps

module tb_traffic_monitor
   import mon_pkg::*;
();

   localparam int DW          = 32;
   localparam int rd_timeout  = 20;
   localparam int flag_limit  = 50;

   logic                clk = 1'b0;
   logic                reset;
   mi_req_t             req;
   link_events_t        events;
   logic [DW-1:0]       rd_data;
   logic                rd_valid;
   logic [num_mons-1:0] zero_flag;

   integer seed = 32'h1c9b;
   int     errors = 0;
   int     timeouts = 0;

   // 40 ns period
   always #20 clk = ~clk;

   traffic_monitor #(
      .DW (DW)
   ) i_traffic_monitor (
      .clk       (clk),
      .reset     (reset),
      .req       (req),
      .events    (events),
      .rd_data   (rd_data),
      .rd_valid  (rd_valid),
      .zero_flag (zero_flag)
   );

   // word address of counter i, rx side first
   function automatic logic [19:0] counter_addr(input int i);
      case (i)
         0:       return reg_rx_mon0;
         1:       return reg_rx_mon1;
         2:       return reg_rx_mon2;
         3:       return reg_tx_mon0;
         4:       return reg_tx_mon1;
         default: return reg_tx_mon2;
      endcase
   endfunction

   // level of the line behind an event code
   function automatic logic selected_line(input link_events_t e, input mon_event_e code);
      case (code)
         ev_rx_rd_access: return e.rx_rd_access;
         ev_rx_rd_wait:   return e.rx_rd_wait;
         ev_rx_wr_access: return e.rx_wr_access;
         ev_rx_wr_wait:   return e.rx_wr_wait;
         ev_rx_wb_access: return e.rx_wb_access;
         ev_rx_wb_wait:   return e.rx_wb_wait;
         ev_tx_rd_access: return e.tx_rd_access;
         ev_tx_rd_wait:   return e.tx_rd_wait;
         ev_tx_wr_access: return e.tx_wr_access;
         ev_tx_wr_wait:   return e.tx_wr_wait;
         ev_tx_wb_access: return e.tx_wb_access;
         ev_tx_wb_wait:   return e.tx_wb_wait;
         // never and the spare codes stay low
         default:         return (code == ev_always);
      endcase
   endfunction

   task automatic report_mismatch(input string test, input string what,
                                  input logic [31:0] exp, input logic [31:0] act);
      errors++;
      $display("[FAIL] %s %s expected %h actual %h", test, what, exp, act);
   endtask

   // one cycle write strobe, takes effect at the next edge
   task automatic bus_write(input logic [19:0] addr, input logic [31:0] data);
      mi_req_t r;
      r.access = 1'b1;
      r.write  = 1'b1;
      r.addr   = addr;
      r.wdata  = data;
      @(posedge clk);
      req <= r;
      @(posedge clk);
      req <= '0;
   endtask

   // read strobe, then wait for rd_valid
   task automatic bus_read(input logic [19:0] addr, output logic [31:0] data);
      mi_req_t r;
      int      n;
      r.access = 1'b1;
      r.write  = 1'b0;
      r.addr   = addr;
      r.wdata  = '0;
      @(posedge clk);
      req <= r;
      @(posedge clk);
      req <= '0;
      @(negedge clk);
      n = 0;
      while (!rd_valid && n < rd_timeout) begin
         @(negedge clk);
         n++;
      end
      if (!rd_valid) begin
         timeouts++;
         $display("read of address %h got no rd_valid within %0d cycles", addr, rd_timeout);
         data = '0;
      end else begin
         data = rd_data;
      end
   endtask

   task automatic reset_state();
      logic [31:0] data;
      bus_read(reg_mon_cfg, data);
      if (data !== 32'd0) report_mismatch("reset_state", "config", 32'd0, data);
      for (int i = 0; i < num_mons; i++) begin
         bus_read(counter_addr(i), data);
         if (data !== 32'd0) report_mismatch("reset_state", "count", 32'd0, data);
      end
      @(negedge clk);
      if (zero_flag !== 6'h3f) report_mismatch("reset_state", "zero_flag", 32'h3f, 32'(zero_flag));
   endtask

   task automatic config_and_load();
      logic [31:0]         cfg_word;
      logic [31:0]         data;
      logic [31:0]         vals [num_mons];
      logic [num_mons-1:0] exp_zero;
      // all select fields ev_never, spare upper byte random
      cfg_word = $random(seed) & 32'hff00_0000;
      bus_write(reg_mon_cfg, cfg_word);
      for (int i = 0; i < num_mons; i++) begin
         vals[i] = $random(seed);
      end
      // one zero load so the flag pattern is mixed
      vals[4] = 32'd0;
      for (int i = 0; i < num_mons; i++) begin
         bus_write(counter_addr(i), vals[i]);
         exp_zero[i] = (vals[i] == 32'd0);
      end
      bus_read(reg_mon_cfg, data);
      if (data !== cfg_word) report_mismatch("config_and_load", "config", cfg_word, data);
      for (int i = 0; i < num_mons; i++) begin
         bus_read(counter_addr(i), data);
         if (data !== vals[i]) report_mismatch("config_and_load", "count", vals[i], data);
      end
      @(negedge clk);
      if (zero_flag !== exp_zero) begin
         report_mismatch("config_and_load", "zero_flag", 32'(exp_zero), 32'(zero_flag));
      end
   endtask

   task automatic always_event();
      logic [31:0] data;
      logic [31:0] exp;
      int          n;
      // load while every field is still ev_never
      for (int i = 0; i < num_mons; i++) begin
         bus_write(counter_addr(i), (i == 2) ? 32'd5 : 32'(10 * (i + 1)));
      end
      bus_write(reg_mon_cfg, 32'(ev_always) << 8);
      n = 0;
      @(negedge clk);
      while (!zero_flag[2] && n < flag_limit) begin
         @(negedge clk);
         n++;
      end
      if (!zero_flag[2]) begin
         timeouts++;
         $display("counter 2 did not reach zero within %0d cycles", flag_limit);
      end
      // keep counting into saturation
      repeat (6) @(posedge clk);
      for (int i = 0; i < num_mons; i++) begin
         exp = (i == 2) ? 32'd0 : 32'(10 * (i + 1));
         bus_read(counter_addr(i), data);
         if (data !== exp) report_mismatch("always_event", "count", exp, data);
      end
   endtask

   task automatic single_source_count();
      logic [31:0] cfg_word;
      logic [31:0] data;
      logic [31:0] exp;
      int          pulses;
      pulses = 7;
      // counter i on the access line with code 2 + 2i
      cfg_word = '0;
      for (int i = 0; i < num_mons; i++) begin
         cfg_word[4*i +: 4] = 4'(2 + 2 * i);
      end
      bus_write(reg_mon_cfg, cfg_word);
      for (int i = 0; i < num_mons; i++) begin
         bus_write(counter_addr(i), 32'd100);
      end
      // tx_rd_access feeds counter 3 only
      repeat (pulses) begin
         @(posedge clk);
         events.tx_rd_access <= 1'b1;
         @(posedge clk);
         events.tx_rd_access <= 1'b0;
      end
      repeat (2) @(posedge clk);
      for (int i = 0; i < num_mons; i++) begin
         exp = (i == 3) ? 32'(100 - pulses) : 32'd100;
         bus_read(counter_addr(i), data);
         if (data !== exp) report_mismatch("single_source_count", "count", exp, data);
      end
   endtask

   task automatic random_traffic();
      mon_event_e   sel [num_mons];
      int           hits [num_mons];
      logic [31:0]  cfg_word;
      logic [31:0]  rnd;
      logic [31:0]  data;
      logic [31:0]  exp;
      link_events_t e;
      sel[0] = ev_rx_rd_wait;
      sel[1] = ev_tx_wr_access;
      sel[2] = ev_rx_wb_access;
      sel[3] = ev_tx_wb_wait;
      sel[4] = ev_rx_wr_wait;
      sel[5] = ev_tx_rd_access;
      cfg_word = '0;
      for (int i = 0; i < num_mons; i++) begin
         cfg_word[4*i +: 4] = sel[i];
         hits[i] = 0;
      end
      bus_write(reg_mon_cfg, cfg_word);
      for (int i = 0; i < num_mons; i++) begin
         bus_write(counter_addr(i), 32'd1000);
      end
      for (int cyc = 0; cyc < 200; cyc++) begin
         rnd = $random(seed);
         e = link_events_t'(rnd[11:0]);
         @(posedge clk);
         events <= e;
         for (int i = 0; i < num_mons; i++) begin
            if (selected_line(e, sel[i])) hits[i]++;
         end
      end
      @(posedge clk);
      events <= '0;
      repeat (2) @(posedge clk);
      for (int i = 0; i < num_mons; i++) begin
         exp = 32'(1000 - hits[i]);
         bus_read(counter_addr(i), data);
         if (data !== exp) report_mismatch("random_traffic", "count", exp, data);
      end
   endtask

   task automatic unmapped_access();
      logic [19:0] holes [4];
      logic [31:0] cfg_word;
      logic [31:0] vals [num_mons];
      logic [31:0] data;
      // neighbours of the map and a far address
      holes[0] = 20'hf0368;
      holes[1] = 20'hf0388;
      holes[2] = 20'hf036d;
      holes[3] = 20'h00000;
      cfg_word = $random(seed) & 32'hff00_0000;
      bus_write(reg_mon_cfg, cfg_word);
      for (int i = 0; i < num_mons; i++) begin
         vals[i] = $random(seed);
         bus_write(counter_addr(i), vals[i]);
      end
      for (int j = 0; j < 4; j++) begin
         bus_write(holes[j], $random(seed));
      end
      bus_read(reg_mon_cfg, data);
      if (data !== cfg_word) report_mismatch("unmapped_access", "config", cfg_word, data);
      for (int i = 0; i < num_mons; i++) begin
         bus_read(counter_addr(i), data);
         if (data !== vals[i]) report_mismatch("unmapped_access", "count", vals[i], data);
      end
      for (int j = 0; j < 4; j++) begin
         bus_read(holes[j], data);
         if (data !== 32'd0) report_mismatch("unmapped_access", "hole read", 32'd0, data);
      end
   endtask

   initial begin
      req    = '0;
      events = '0;
      reset  = 1'b1;
      repeat (5) @(posedge clk);
      reset <= 1'b0;
      reset_state();
      config_and_load();
      always_event();
      single_source_count();
      random_traffic();
      unmapped_access();
      repeat (2) @(posedge clk);
      $display("mismatches: %0d timeouts: %0d", errors, timeouts);
      if (errors == 0 && timeouts == 0) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

endmodule

// File: test/traffic_monitor_assert.sv
/*
  traffic monitor assertions
  read strobe timing on the slave port and the reset state,
  bound to the top level
*/
`timescale 1ns/10ps

module traffic_monitor_assert
   import mon_pkg::*;
(
   input logic                clk,
   input logic                reset,
   input mi_req_t             req,
   input logic                rd_valid,
   input logic [num_mons-1:0] zero_flag
);

   logic rd_req;

   // read request strobe
   assign rd_req = req.access & ~req.write;

   // every read answered in the next cycle
   a_read_answered: assert property (
      @(posedge clk) disable iff (reset) rd_req |=> rd_valid
   ) else $error("rd_valid missing one cycle after a read request");

   // no valid strobe without a read before it
   a_valid_only_after_read: assert property (
      @(posedge clk) disable iff (reset) rd_valid |-> $past(rd_req)
   ) else $error("rd_valid high without a read request in the cycle before");

   // counters and strobe cleared by reset
   a_reset_state: assert property (
      @(posedge clk) reset |=> (!rd_valid && (zero_flag == '1))
   ) else $error("rd_valid or zero_flag wrong in the cycle after reset");

endmodule

bind traffic_monitor traffic_monitor_assert i_traffic_monitor_assert (
   .clk       (clk),
   .reset     (reset),
   .req       (req),
   .rd_valid  (rd_valid),
   .zero_flag (zero_flag)
);

// File: rtl/traffic_monitor.sv
/*
  link traffic monitor top
  samples the link fifo strobes, runs six event counters on
  selectable entries and serves them on the slave port
  DW must be at least 24 to hold the six select fields
*/
`timescale 1ns/10ps

module traffic_monitor
   import mon_pkg::*;
#(
   parameter int DW = 32
) (
   input  logic                clk,
   input  logic                reset,
   input  mi_req_t             req,
   input  link_events_t        events,
   output logic [DW-1:0]       rd_data,
   output logic                rd_valid,
   output logic [num_mons-1:0] zero_flag
);

   // shared event vector
   logic [ev_vec_w-1:0]         ev_vec;

   // register block to counters
   mon_cfg_t                    cfg;
   logic [num_mons-1:0]         load;
   logic [DW-1:0]               load_data;

   // counters back to readback
   logic [num_mons-1:0][DW-1:0] counts;

   event_sampler i_event_sampler (
      .clk    (clk),
      .reset  (reset),
      .events (events),
      .ev_vec (ev_vec)
   );

   mon_regs #(
      .DW (DW)
   ) i_mon_regs (
      .clk       (clk),
      .reset     (reset),
      .req       (req),
      .counts    (counts),
      .cfg       (cfg),
      .load      (load),
      .load_data (load_data),
      .rd_data   (rd_data),
      .rd_valid  (rd_valid)
   );

   // counters 0..2 on rx addresses, 3..5 on tx addresses
   for (genvar i = 0; i < num_mons; i++) begin : gen_mon
      event_counter #(
         .DW (DW)
      ) i_event_counter (
         .clk       (clk),
         .reset     (reset),
         .ev_vec    (ev_vec),
         .sel       (cfg[i]),
         .load      (load[i]),
         .load_data (load_data),
         .count     (counts[i]),
         .zero      (zero_flag[i])
      );
   end

endmodule

// File: rtl/mon_regs.sv
/*
  monitor register block
  decodes the slave port, holds the configuration register,
  issues counter load strobes and returns registered readback
  one cycle after each read request
*/
`timescale 1ns/10ps

module mon_regs
   import mon_pkg::*;
#(
   parameter int DW = 32
) (
   input  logic                         clk,
   input  logic                         reset,
   input  mi_req_t                      req,
   input  logic [num_mons-1:0][DW-1:0]  counts,
   output mon_cfg_t                     cfg,
   output logic [num_mons-1:0]          load,
   output logic [DW-1:0]                load_data,
   output logic [DW-1:0]                rd_data,
   output logic                         rd_valid
);

   // counter addresses, index i for counter i
   localparam logic [num_mons-1:0][19:0] mon_addr = {
      reg_tx_mon2,
      reg_tx_mon1,
      reg_tx_mon0,
      reg_rx_mon2,
      reg_rx_mon1,
      reg_rx_mon0
   };

   logic                rd_req;
   logic                wr_req;
   logic                cfg_hit;
   logic [num_mons-1:0] mon_hit;
   logic [DW-1:0]       wdata;
   logic [DW-1:0]       cfg_reg;
   logic [DW-1:0]       rd_mux;

   // request type
   assign rd_req = req.access & ~req.write;
   assign wr_req = req.access & req.write;

   // address match
   assign cfg_hit = (req.addr == reg_mon_cfg);

   always_comb begin
      for (int i = 0; i < num_mons; i++) begin
         mon_hit[i] = (req.addr == mon_addr[i]);
      end
   end

   // bus data resized to the counter width
   assign wdata = DW'(req.wdata);

   // configuration register, whole word kept for readback
   always_ff @(posedge clk) begin
      if (reset) begin
         cfg_reg <= '0;
      end else if (wr_req && cfg_hit) begin
         cfg_reg <= wdata;
      end
   end

   // four bit select field per counter
   always_comb begin
      for (int i = 0; i < num_mons; i++) begin
         cfg[i] = mon_event_e'(cfg_reg[4*i +: 4]);
      end
   end

   // load strobes, same cycle as the write request
   assign load      = {num_mons{wr_req}} & mon_hit;
   assign load_data = wdata;

   // readback select
   // addresses are exclusive, so an or of masked words is enough
   // unmapped addresses fall through as zero
   always_comb begin
      rd_mux = {DW{cfg_hit}} & cfg_reg;
      for (int i = 0; i < num_mons; i++) begin
         rd_mux = rd_mux | ({DW{mon_hit[i]}} & counts[i]);
      end
   end

   // read data held until the next read
   always_ff @(posedge clk) begin
      if (rd_req) begin
         rd_data <= rd_mux;
      end
   end

   // one cycle valid strobe per read
   always_ff @(posedge clk) begin
      if (reset) begin
         rd_valid <= 1'b0;
      end else begin
         rd_valid <= rd_req;
      end
   end

endmodule

// File: rtl/event_counter.sv
/*
  event counter
  loadable down-counter, decrements once per cycle while its
  selected event entry is high, stops at zero and flags it
*/
`timescale 1ns/10ps

module event_counter
   import mon_pkg::*;
#(
   parameter int DW = 32
) (
   input  logic                clk,
   input  logic                reset,
   input  logic [ev_vec_w-1:0] ev_vec,
   input  mon_event_e          sel,
   input  logic                load,
   input  logic [DW-1:0]       load_data,
   output logic [DW-1:0]       count,
   output logic                zero
);

   logic hit;
   logic dec;

   // selected entry of the event vector
   assign hit = ev_vec[sel];

   // saturate at zero
   assign dec = hit & ~zero;

   always_ff @(posedge clk) begin
      if (reset) begin
         count <= '0;
      end else if (load) begin
         // load wins over a decrement in the same cycle
         count <= load_data;
      end else if (dec) begin
         count <= count - 1'b1;
      end
   end

   // straight compare, follows the count register
   assign zero = (count == '0);

endmodule

// File: rtl/event_sampler.sv
/*
  event sampler
  registers the twelve link fifo strobes once and lays them
  out as the sixteen entry event vector indexed by event code
*/
`timescale 1ns/10ps

module event_sampler
   import mon_pkg::*;
(
   input  logic                clk,
   input  logic                reset,
   input  link_events_t        events,
   output logic [ev_vec_w-1:0] ev_vec
);

   logic [ev_vec_w-1:0] ev_next;

   // place each strobe at the index of its code
   always_comb begin
      ev_next = '0;
      // entry 0 stays low, entry 1 fires every cycle
      ev_next[ev_always]       = 1'b1;
      // receive side
      ev_next[ev_rx_rd_access] = events.rx_rd_access;
      ev_next[ev_rx_rd_wait]   = events.rx_rd_wait;
      ev_next[ev_rx_wr_access] = events.rx_wr_access;
      ev_next[ev_rx_wr_wait]   = events.rx_wr_wait;
      ev_next[ev_rx_wb_access] = events.rx_wb_access;
      ev_next[ev_rx_wb_wait]   = events.rx_wb_wait;
      // transmit side
      ev_next[ev_tx_rd_access] = events.tx_rd_access;
      ev_next[ev_tx_rd_wait]   = events.tx_rd_wait;
      ev_next[ev_tx_wr_access] = events.tx_wr_access;
      ev_next[ev_tx_wr_wait]   = events.tx_wr_wait;
      ev_next[ev_tx_wb_access] = events.tx_wb_access;
      ev_next[ev_tx_wb_wait]   = events.tx_wb_wait;
      // codes 14 and 15 left low
   end

   // one register stage, whole vector clear in reset
   always_ff @(posedge clk) begin
      if (reset) begin
         ev_vec <= '0;
      end else begin
         ev_vec <= ev_next;
      end
   end

endmodule

// File: rtl/mon_pkg.sv
/*
  link traffic monitor shared definitions
  register map of the slave port, event select codes,
  link event lines and the slave request bundle
*/
package mon_pkg;

   // number of event counters, fixed by the register map
   localparam int num_mons = 6;

   // event vector seen by every counter
   localparam int ev_vec_w = 16;

   // slave port word addresses
   localparam logic [19:0] reg_mon_cfg = 20'hf036c;
   localparam logic [19:0] reg_rx_mon0 = 20'hf0370;
   localparam logic [19:0] reg_rx_mon1 = 20'hf0374;
   localparam logic [19:0] reg_rx_mon2 = 20'hf0378;
   localparam logic [19:0] reg_tx_mon0 = 20'hf037c;
   localparam logic [19:0] reg_tx_mon1 = 20'hf0380;
   localparam logic [19:0] reg_tx_mon2 = 20'hf0384;

   // event select codes, one per event vector entry
   typedef enum logic [3:0] {
      ev_never        = 4'd0,
      ev_always       = 4'd1,
      ev_rx_rd_access = 4'd2,
      ev_rx_rd_wait   = 4'd3,
      ev_rx_wr_access = 4'd4,
      ev_rx_wr_wait   = 4'd5,
      ev_rx_wb_access = 4'd6,
      ev_rx_wb_wait   = 4'd7,
      ev_tx_rd_access = 4'd8,
      ev_tx_rd_wait   = 4'd9,
      ev_tx_wr_access = 4'd10,
      ev_tx_wr_wait   = 4'd11,
      ev_tx_wb_access = 4'd12,
      ev_tx_wb_wait   = 4'd13,
      ev_rsvd14       = 4'd14,
      ev_rsvd15       = 4'd15
   } mon_event_e;

   // one select code per counter
   typedef mon_event_e [num_mons-1:0] mon_cfg_t;

   // link fifo strobes, tx side in the upper bits
   typedef struct packed {
      logic tx_wb_wait;
      logic tx_wb_access;
      logic tx_wr_wait;
      logic tx_wr_access;
      logic tx_rd_wait;
      logic tx_rd_access;
      logic rx_wb_wait;
      logic rx_wb_access;
      logic rx_wr_wait;
      logic rx_wr_access;
      logic rx_rd_wait;
      logic rx_rd_access;
   } link_events_t;

   // single cycle slave request, no back-pressure
   typedef struct packed {
      logic        access;
      logic        write;
      logic [19:0] addr;
      logic [31:0] wdata;
   } mi_req_t;

endpackage
